/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_net_stack -f files.f
	out="$$(./obj_dir/Vtb_net_stack)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* files.f */
net_pkg.sv
net_stream_if.sv
net_reset_timer.sv
net_stream_fifo.sv
net_frame_padder.sv
net_pkt_fifo.sv
net_stack_top.sv
tb_net_checker.sv
tb_net_stack.sv

/* net_frame_padder.sv */
// --------------------------------------
// Transmit frame padder. Extends short
// frames with zero bytes to 64 bytes.
// --------------------------------------
module net_frame_padder (
  input  logic         rclk,
  input  logic         rst,
  net_stream_if.sink   in_s,
  net_stream_if.source out_s
);

  net_pkg::pad_state_t state;     // Passing user beats or appending fill.
  net_pkg::beat_cnt_t  beat_idx;  // Index of the next output beat.
  logic                at_min;    // Next output beat is the minimum last beat.
  logic                below_min; // Frame would still be too short if it ended here.
  logic                out_fire;  // Output beat accepted downstream.

  // Zeroes every byte whose keep bit is clear.
  function automatic net_pkg::data_t mask_bytes(input net_pkg::data_t data,
                                                input net_pkg::keep_t keep);
    net_pkg::data_t result;
    result = '0;
    for (int i = 0; i < net_pkg::DATA_BYTES; i++) begin
      if (keep[i]) begin
        result[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    return result;
  endfunction

  assign at_min    = (beat_idx == net_pkg::beat_cnt_t'(net_pkg::MIN_FRAME_BEATS - 1));
  assign below_min = (beat_idx <  net_pkg::beat_cnt_t'(net_pkg::MIN_FRAME_BEATS - 1));
  assign out_fire  = out_s.valid & out_s.ready;

  always_comb begin
    if (state == net_pkg::PAD_FILL) begin
      // The user frame is already over, so hold the input off.
      in_s.ready  = 1'b0;
      out_s.valid = 1'b1;
      out_s.data  = '0;
      out_s.keep  = '1;
      out_s.last  = at_min;  // Fill stops exactly at the minimum length.
    end else begin
      // Zero latency in both directions.
      in_s.ready  = out_s.ready;
      out_s.valid = in_s.valid;
      if (in_s.last && (below_min || at_min)) begin
        // A frame ending on or before the minimum beat gets full keep.
        // The bytes beyond the original keep go out as zero.
        out_s.data = mask_bytes(in_s.data, in_s.keep);
        out_s.keep = '1;
        out_s.last = at_min;  // Below the minimum the fill beats carry last.
      end else begin
        out_s.data = in_s.data;  // Middle beats and long frames pass untouched.
        out_s.keep = in_s.keep;
        out_s.last = in_s.last;
      end
    end
  end

  always_ff @(posedge rclk) begin
    if (rst) begin
      state    <= net_pkg::PAD_PASS;
      beat_idx <= '0;
    end else begin
      if (out_fire) begin
        if (out_s.last) begin
          beat_idx <= '0;  // Every frame counts from zero again.
        end else if (beat_idx != '1) begin
          beat_idx <= beat_idx + net_pkg::beat_cnt_t'(1);  // Saturates on long frames.
        end
      end
      case (state)
        net_pkg::PAD_PASS: begin
          // In this state an output handshake is also the input handshake.
          if (out_fire && in_s.last && below_min) begin
            state <= net_pkg::PAD_FILL;
          end
        end
        net_pkg::PAD_FILL: begin
          if (out_fire && out_s.last) begin
            state <= net_pkg::PAD_PASS;
          end
        end
        default: state <= net_pkg::PAD_PASS;
      endcase
    end
  end

endmodule

/* net_pkg.sv */
// --------------------------------------
// Shared sizes, types and encodings of
// the network interface user datapath.
// --------------------------------------
package net_pkg;

  // One beat carries eight bytes, so the datapath is 64 bits wide.
  localparam int DATA_BYTES = 8;
  localparam int DATA_BITS  = DATA_BYTES * 8;

  // A 64-byte Ethernet minimum frame spans this many beats.
  localparam int MIN_FRAME_BEATS = 64 / DATA_BYTES;

  // Depth of every stream FIFO in beats.
  // This is also the longest transmit frame the packet FIFO can hold.
  localparam int FIFO_DEPTH = 32;

  // Both link resets must stay low this many cycles before net_ready rises.
  localparam int RESET_HOLD_CYCLES = 16;

  typedef logic [DATA_BITS-1:0]  data_t;  // One beat of frame data.
  typedef logic [DATA_BYTES-1:0] keep_t;  // Bit i marks byte i as valid.

  // Beat index inside a frame. It saturates at all ones on long frames.
  typedef logic [4:0] beat_cnt_t;

  // FIFO read and write pointers wrap naturally at FIFO_DEPTH.
  typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;

  // Occupancy needs one extra bit so that a full FIFO is representable.
  typedef logic [$clog2(FIFO_DEPTH):0] fill_t;

  // Reset-hold counter, wide enough to reach RESET_HOLD_CYCLES.
  typedef logic [4:0] hold_t;

  // Padder states.
  typedef enum logic {
    PAD_PASS = 1'b0,  // Beats flow straight from input to output.
    PAD_FILL = 1'b1   // Zero beats are appended up to the minimum length.
  } pad_state_t;

endpackage

/* net_pkt_fifo.sv */
// --------------------------------------
// Store-and-forward packet FIFO. Only
// complete frames are released.
// --------------------------------------
module net_pkt_fifo (
  input  logic         rclk,
  input  logic         rst,
  net_stream_if.sink   in_s,
  net_stream_if.source out_s
);

  // Frames longer than FIFO_DEPTH beats are not supported.
  // Such a frame fills the buffer before its last beat arrives and stalls for good.

  net_stream_if fifo_out ();  // Ungated output of the beat buffer.

  net_pkg::fill_t frame_cnt;    // Complete frames held in the buffer.
  logic           frame_avail;  // At least one whole frame is stored.
  logic           frame_in;     // A last beat is written this cycle.
  logic           frame_out;    // A last beat leaves this cycle.

  net_stream_fifo buf_i (
    .rclk  (rclk),
    .rst   (rst),
    .in_s  (in_s),
    .out_s (fifo_out)
  );

  assign frame_avail = (frame_cnt != '0);
  assign frame_in    = in_s.valid & in_s.ready & in_s.last;
  assign frame_out   = out_s.valid & out_s.ready & out_s.last;

  // The head beat is hidden until its frame is complete.
  // After that the rest of the frame is already stored, so it bursts out unbroken.
  assign out_s.valid    = fifo_out.valid & frame_avail;
  assign fifo_out.ready = out_s.ready & frame_avail;
  assign out_s.data     = fifo_out.data;
  assign out_s.keep     = fifo_out.keep;
  assign out_s.last     = fifo_out.last;

  // The count updates on the write edge.
  // So a frame shows up one cycle after its last beat at the earliest.
  always_ff @(posedge rclk) begin
    if (rst) begin
      frame_cnt <= '0;
    end else begin
      case ({frame_in, frame_out})
        2'b10:   frame_cnt <= frame_cnt + net_pkg::fill_t'(1);
        2'b01:   frame_cnt <= frame_cnt - net_pkg::fill_t'(1);
        default: frame_cnt <= frame_cnt;  // Both or neither.
      endcase
    end
  end

endmodule

/* net_reset_timer.sv */
// --------------------------------------
// Reset-hold timer. Turns the two MAC
// link resets into a debounced net_ready.
// --------------------------------------
module net_reset_timer (
  input  logic rclk,
  input  logic rst,
  input  logic link_tx_reset,
  input  logic link_rx_reset,
  output logic net_ready
);

  net_pkg::hold_t hold_cnt;   // Edges seen with every reset input low.
  logic           any_reset;  // At least one reset source is active.
  logic           hold_done;  // The quiet period has run its full length.

  assign any_reset = rst | link_tx_reset | link_rx_reset;
  assign hold_done = (hold_cnt == net_pkg::hold_t'(net_pkg::RESET_HOLD_CYCLES));

  // The first quiet edge loads one, so the count reaches RESET_HOLD_CYCLES
  // one edge before net_ready is registered high.
  always_ff @(posedge rclk) begin
    if (any_reset) begin
      hold_cnt  <= '0;    // Any reset restarts the quiet period.
      net_ready <= 1'b0;  // Drops on the edge that samples the reset.
    end else begin
      if (hold_done) begin
        net_ready <= 1'b1;  // Stays high until a reset shows up again.
      end else begin
        hold_cnt <= hold_cnt + net_pkg::hold_t'(1);
      end
    end
  end

  // The count parks at RESET_HOLD_CYCLES once it is reached.
  // It never wraps, so a long quiet period keeps net_ready steady.
  // Either link reset alone is enough to pull the datapath back into reset.

endmodule

/* net_stack_top.sv */
// --------------------------------------
// Network interface user datapath. RX
// FIFO, TX padder and packet FIFO.
// --------------------------------------
module net_stack_top (
  input  logic           rclk,
  input  logic           rst,
  input  logic           link_tx_reset,
  input  logic           link_rx_reset,
  output logic           net_ready,
  // Receive stream from the MAC.
  input  logic           rx_mac_valid,
  input  net_pkg::data_t rx_mac_data,
  input  net_pkg::keep_t rx_mac_keep,
  input  logic           rx_mac_last,
  output logic           rx_mac_ready,
  // Receive stream to the user.
  output logic           rx_usr_valid,
  output net_pkg::data_t rx_usr_data,
  output net_pkg::keep_t rx_usr_keep,
  output logic           rx_usr_last,
  input  logic           rx_usr_ready,
  // Transmit stream from the user.
  input  logic           tx_usr_valid,
  input  net_pkg::data_t tx_usr_data,
  input  net_pkg::keep_t tx_usr_keep,
  input  logic           tx_usr_last,
  output logic           tx_usr_ready,
  // Transmit stream to the MAC.
  output logic           tx_mac_valid,
  output net_pkg::data_t tx_mac_data,
  output net_pkg::keep_t tx_mac_keep,
  output logic           tx_mac_last,
  input  logic           tx_mac_ready
);

  logic dp_rst;  // Datapath reset, held until the link has settled.

  net_stream_if rx_in ();      // MAC side of the receive FIFO.
  net_stream_if rx_out ();     // User side of the receive FIFO.
  net_stream_if tx_in ();      // User frames into the padder.
  net_stream_if tx_padded ();  // Padded frames into the packet FIFO.
  net_stream_if tx_out ();     // Whole frames toward the MAC.

  assign dp_rst = rst | ~net_ready;

  net_reset_timer reset_timer_i (
    .rclk          (rclk),
    .rst           (rst),
    .link_tx_reset (link_tx_reset),
    .link_rx_reset (link_rx_reset),
    .net_ready     (net_ready)
  );

  // The datapath reset takes hold one edge after net_ready falls.
  // Gating the handshake ports with net_ready keeps them quiet in that cycle too.

  // Receive path. The MAC stream is buffered and handed on unchanged.
  assign rx_in.valid  = rx_mac_valid;
  assign rx_in.data   = rx_mac_data;
  assign rx_in.keep   = rx_mac_keep;
  assign rx_in.last   = rx_mac_last;
  assign rx_mac_ready = rx_in.ready & net_ready;

  net_stream_fifo rx_fifo (.rclk(rclk), .rst(dp_rst), .in_s(rx_in), .out_s(rx_out));

  assign rx_usr_valid = rx_out.valid & net_ready;
  assign rx_usr_data  = rx_out.data;
  assign rx_usr_keep  = rx_out.keep;
  assign rx_usr_last  = rx_out.last;
  assign rx_out.ready = rx_usr_ready;

  // Transmit path. Frames are padded first, then stored whole.
  assign tx_in.valid  = tx_usr_valid;
  assign tx_in.data   = tx_usr_data;
  assign tx_in.keep   = tx_usr_keep;
  assign tx_in.last   = tx_usr_last;
  assign tx_usr_ready = tx_in.ready & net_ready;

  net_frame_padder padder_i (.rclk(rclk), .rst(dp_rst), .in_s(tx_in), .out_s(tx_padded));

  net_pkt_fifo tx_pkt_fifo (.rclk(rclk), .rst(dp_rst), .in_s(tx_padded), .out_s(tx_out));

  assign tx_mac_valid = tx_out.valid & net_ready;  // One unbroken burst per frame.
  assign tx_mac_data  = tx_out.data;
  assign tx_mac_keep  = tx_out.keep;
  assign tx_mac_last  = tx_out.last;
  assign tx_out.ready = tx_mac_ready;

endmodule

/* net_stream_fifo.sv */
// --------------------------------------
// Synchronous stream FIFO holding data,
// keep and last of each beat.
// --------------------------------------
module net_stream_fifo (
  input  logic         rclk,
  input  logic         rst,
  net_stream_if.sink   in_s,
  net_stream_if.source out_s
);

  // Beat storage, one entry per beat.
  net_pkg::data_t data_mem [net_pkg::FIFO_DEPTH];
  net_pkg::keep_t keep_mem [net_pkg::FIFO_DEPTH];
  logic           last_mem [net_pkg::FIFO_DEPTH];

  net_pkg::ptr_t  wr_ptr;      // Next entry to write.
  net_pkg::ptr_t  rd_ptr;      // Entry shown at the output.
  net_pkg::fill_t fill;        // Beats currently stored.
  net_pkg::fill_t fill_next;   // Occupancy after this edge.
  logic           in_ready_q;  // Registered "not full", low in reset.
  logic           wr_en;       // A beat is accepted at the input.
  logic           rd_en;       // A beat leaves at the output.

  assign wr_en = in_s.valid & in_ready_q;
  assign rd_en = out_s.valid & out_s.ready;

  assign in_s.ready  = in_ready_q;
  assign out_s.valid = (fill != '0);  // Empty comes straight from the count.

  // The head entry is read combinationally.
  // A written beat thus shows up one cycle after its write edge.
  assign out_s.data = data_mem[rd_ptr];
  assign out_s.keep = keep_mem[rd_ptr];
  assign out_s.last = last_mem[rd_ptr];

  // A write and a read on the same edge leave the count unchanged.
  always_comb begin
    fill_next = fill;
    case ({wr_en, rd_en})
      2'b10:   fill_next = fill + net_pkg::fill_t'(1);
      2'b01:   fill_next = fill - net_pkg::fill_t'(1);
      default: fill_next = fill;
    endcase
  end

  always_ff @(posedge rclk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      in_ready_q <= 1'b0;  // No beats are taken while the datapath is in reset.
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + net_pkg::ptr_t'(1);  // Wraps at FIFO_DEPTH.
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + net_pkg::ptr_t'(1);
      end
      fill <= fill_next;
      // Full is derived from the same next count, so ready tracks fill exactly.
      in_ready_q <= (fill_next < net_pkg::fill_t'(net_pkg::FIFO_DEPTH));
    end
  end

  // Each accepted beat lands in the entry at the write pointer.
  always_ff @(posedge rclk) begin
    if (wr_en) begin
      data_mem[wr_ptr] <= in_s.data;
      keep_mem[wr_ptr] <= in_s.keep;
      last_mem[wr_ptr] <= in_s.last;
    end
  end

endmodule

/* net_stream_if.sv */
// --------------------------------------
// Valid/ready beat stream with byte keep
// and end-of-frame marker.
// --------------------------------------
interface net_stream_if;

  logic           valid;  // Source has a beat on the bus.
  logic           ready;  // Sink can take a beat this cycle.
  net_pkg::data_t data;   // Beat payload, byte 0 in the low bits.
  net_pkg::keep_t keep;   // Contiguous from bit 0; partial only on a last beat.
  logic           last;   // Marks the final beat of a frame.

  // The source holds data, keep and last steady while valid waits on ready.
  modport source (
    output valid,
    output data,
    output keep,
    output last,
    input  ready
  );

  // The sink only answers with ready.
  modport sink (
    input  valid,
    input  data,
    input  keep,
    input  last,
    output ready
  );

endinterface

/* tb_net_checker.sv */
// --------------------------------------
// Testbench checker. Models the datapath
// from input handshakes, compares outputs.
// --------------------------------------
module tb_net_checker (
  input  logic           rclk,
  input  logic           net_ready,
  input  logic [127:0]   test_name,     // Name of the running test, as text.
  input  logic           rx_mac_valid,
  input  net_pkg::data_t rx_mac_data,
  input  net_pkg::keep_t rx_mac_keep,
  input  logic           rx_mac_last,
  input  logic           rx_mac_ready,
  input  logic           rx_usr_valid,
  input  net_pkg::data_t rx_usr_data,
  input  net_pkg::keep_t rx_usr_keep,
  input  logic           rx_usr_last,
  input  logic           rx_usr_ready,
  input  logic           tx_usr_valid,
  input  net_pkg::data_t tx_usr_data,
  input  net_pkg::keep_t tx_usr_keep,
  input  logic           tx_usr_last,
  input  logic           tx_usr_ready,
  input  logic           tx_mac_valid,
  input  net_pkg::data_t tx_mac_data,
  input  net_pkg::keep_t tx_mac_keep,
  input  logic           tx_mac_last,
  input  logic           tx_mac_ready,
  output int             err_cnt,
  output int             rx_pend,
  output int             tx_pend
);

  localparam int LAST_IDX = net_pkg::MIN_FRAME_BEATS - 1;  // Index of a minimum frame's last beat.

  // Each entry is {last, keep, data}.
  logic [72:0]        rx_q [$];
  logic [72:0]        tx_q [$];
  net_pkg::beat_cnt_t tx_idx;       // Beat index of the next user transmit beat.
  logic               tx_in_frame;  // A tx_mac frame has started and not yet ended.
  logic [72:0]        exp_beat;
  logic [72:0]        act_beat;
  net_pkg::data_t     masked;

  // Clears every byte whose keep bit is low.
  function automatic net_pkg::data_t keep_bytes(input net_pkg::data_t d, input net_pkg::keep_t k);
    net_pkg::data_t m;
    for (int i = 0; i < net_pkg::DATA_BYTES; i++) begin
      m[i*8 +: 8] = {8{k[i]}};
    end
    return d & m;
  endfunction

  initial begin
    err_cnt     = 0;
    rx_pend     = 0;
    tx_pend     = 0;
    tx_idx      = '0;
    tx_in_frame = 1'b0;
  end

  always @(posedge rclk) begin
    if (!net_ready) begin
      rx_q.delete();  // The datapath is in reset, so nothing in flight survives.
      tx_q.delete();
      tx_idx      = '0;
      tx_in_frame = 1'b0;
    end else begin
      if (rx_mac_valid && rx_mac_ready) begin
        rx_q.push_back({rx_mac_last, rx_mac_keep, rx_mac_data});  // Receive is a plain copy.
      end
      if (tx_usr_valid && tx_usr_ready) begin
        masked = keep_bytes(tx_usr_data, tx_usr_keep);
        if (tx_usr_last && (int'(tx_idx) < LAST_IDX)) begin
          // Short frame. Full keep here, then zero beats up to the minimum.
          tx_q.push_back({1'b0, {net_pkg::DATA_BYTES{1'b1}}, masked});
          for (int i = int'(tx_idx) + 1; i <= LAST_IDX; i++) begin
            tx_q.push_back({(i == LAST_IDX), {net_pkg::DATA_BYTES{1'b1}}, 64'h0});
          end
        end else if (tx_usr_last && (int'(tx_idx) == LAST_IDX)) begin
          tx_q.push_back({1'b1, {net_pkg::DATA_BYTES{1'b1}}, masked});
        end else begin
          tx_q.push_back({tx_usr_last, tx_usr_keep, tx_usr_data});  // Long frames pass as is.
        end
        if (tx_usr_last) begin
          tx_idx = '0;
        end else if (tx_idx != '1) begin
          tx_idx = tx_idx + net_pkg::beat_cnt_t'(1);
        end
      end
      if (rx_usr_valid && rx_usr_ready) begin
        act_beat = {rx_usr_last, rx_usr_keep, rx_usr_data};
        if (rx_q.size() == 0) begin
          $display("%0s: rx_usr delivered a beat that was never received", test_name);
          err_cnt++;
        end else begin
          exp_beat = rx_q.pop_front();
          if (exp_beat !== act_beat) begin
            $display("ERR %0s rx_usr expected %h actual %h", test_name, exp_beat, act_beat);
            err_cnt++;
          end
        end
      end
      // A started frame never loses valid before its last beat.
      if (tx_in_frame && !tx_mac_valid) begin
        $display("ERR %0s tx_mac_valid expected 1 actual 0", test_name);
        err_cnt++;
      end
      if (tx_mac_valid && tx_mac_ready) begin
        act_beat    = {tx_mac_last, tx_mac_keep, tx_mac_data};
        tx_in_frame = !tx_mac_last;
        if (tx_q.size() == 0) begin
          $display("%0s: tx_mac sent a beat that the user never gave", test_name);
          err_cnt++;
        end else begin
          exp_beat = tx_q.pop_front();
          if (exp_beat !== act_beat) begin
            $display("ERR %0s tx_mac expected %h actual %h", test_name, exp_beat, act_beat);
            err_cnt++;
          end
        end
      end
    end
    rx_pend = rx_q.size();
    tx_pend = tx_q.size();
  end

endmodule

/* tb_net_stack.sv */
// --------------------------------------
// Testbench for the user datapath. Drives
// random frames and reports each test.
// --------------------------------------
module tb_net_stack;

  localparam int TMO = 2000;  // Cycle limit of every wait loop.

  logic           rclk, rst, link_tx_reset, link_rx_reset, net_ready;
  logic           rx_mac_valid, rx_mac_last, rx_mac_ready;
  logic           rx_usr_valid, rx_usr_last, rx_usr_ready;
  logic           tx_usr_valid, tx_usr_last, tx_usr_ready;
  logic           tx_mac_valid, tx_mac_last, tx_mac_ready;
  net_pkg::data_t rx_mac_data, rx_usr_data, tx_usr_data, tx_mac_data;
  net_pkg::keep_t rx_mac_keep, rx_usr_keep, tx_usr_keep, tx_mac_keep;
  logic [127:0]   test_name;
  int             err_cnt, rx_pend, tx_pend;
  int             tb_err;     // Failures found by the sequence itself.
  int             err_start;  // Failure total when the current test began.
  int             passed, failed, edges;
  logic [15:0]    lfsr;
  logic           rx_bp, tx_bp;  // Random back-pressure on the output readies.

  net_stack_top dut_i (.*);
  tb_net_checker chk_i (.*);

  initial begin
    rclk = 1'b0;
    forever #4 rclk = ~rclk;
  end

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit taken.
  function automatic int unsigned rand_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r = (r << 1) | int'(lfsr[0]);
    end
    return r;
  endfunction

  always @(posedge rclk) begin
    rx_usr_ready <= rx_bp ? (rand_bits(2) != 0) : 1'b1;
    tx_mac_ready <= tx_bp ? (rand_bits(2) != 0) : 1'b1;
  end

  task automatic drive_beat(input bit to_rx, input logic v, input net_pkg::data_t d,
                            input net_pkg::keep_t k, input logic l);
    if (to_rx) begin
      rx_mac_valid <= v;
      rx_mac_data  <= d;
      rx_mac_keep  <= k;
      rx_mac_last  <= l;
    end else begin
      tx_usr_valid <= v;
      tx_usr_data  <= d;
      tx_usr_keep  <= k;
      tx_usr_last  <= l;
    end
  endtask

  // Sends one frame. Gives up when net_ready drops in the middle.
  task automatic send_frame(input bit to_rx, input int len, output bit aborted);
    bit             done;
    int             cnt;
    net_pkg::keep_t k;
    aborted = 1'b0;
    for (int b = 0; b < len && !aborted; b++) begin
      if (rand_bits(1) == 1) begin  // Valid gap of one to four cycles.
        @(posedge rclk);
        drive_beat(to_rx, 1'b0, '0, '0, 1'b0);
        repeat (rand_bits(2)) @(posedge rclk);
      end
      k = (b == len - 1) ? net_pkg::keep_t'((1 << (rand_bits(3) + 1)) - 1) : '1;
      @(posedge rclk);
      drive_beat(to_rx, 1'b1, {rand_bits(32), rand_bits(32)}, k, b == len - 1);
      done = 1'b0;
      cnt  = 0;
      while (!done && !aborted) begin
        @(negedge rclk);  // Ready is stable here, the next edge moves the beat.
        cnt = cnt + 1;
        if (!net_ready) begin
          aborted = 1'b1;
        end else if (to_rx ? rx_mac_ready : tx_usr_ready) begin
          done = 1'b1;
        end else if (cnt > TMO) begin
          $display("Timed out waiting for the DUT to accept an input beat.");
          tb_err++;
          aborted = 1'b1;
        end else begin
          @(posedge rclk);
        end
      end
    end
    @(posedge rclk);
    drive_beat(to_rx, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic run_frames(input bit to_rx, input int n, input int lo, input int hi);
    bit aborted;
    for (int f = 0; f < n; f++) begin
      send_frame(to_rx, lo + int'(rand_bits(5) % unsigned'(hi - lo + 1)), aborted);
      if (aborted) break;
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    do begin
      @(negedge rclk);
      cnt = cnt + 1;
    end while ((rx_pend != 0 || tx_pend != 0 || rx_usr_valid || tx_mac_valid) && cnt < TMO);
    if (cnt >= TMO) begin
      $display("Timed out waiting for the DUT to deliver all expected frames.");
      tb_err++;
    end
  endtask

  task automatic wait_net_ready();
    int cnt;
    cnt = 0;
    while (!net_ready && cnt < TMO) begin
      @(negedge rclk);
      cnt = cnt + 1;
    end
    if (!net_ready) begin
      $display("Timed out waiting for net_ready to rise.");
      tb_err++;
    end
  endtask

  // Outputs and readies must all be quiet while the link is held in reset.
  task automatic check_idle();
    if (net_ready || rx_usr_valid || tx_mac_valid || rx_mac_ready || tx_usr_ready) begin
      $display("%0s: DUT is active while net_ready should be low", test_name);
      tb_err++;
    end
  endtask

  task automatic start_test(input logic [127:0] name);
    test_name = name;
    err_start = err_cnt + tb_err;
  endtask

  task automatic end_test();
    if (err_cnt + tb_err == err_start) begin
      $display("PASS %0s", test_name);
      passed++;
    end else begin
      $display("FAIL %0s", test_name);
      failed++;
    end
  endtask

  initial begin
    lfsr = 16'd74;
    {tb_err, err_start, passed, failed} = '0;
    rst = 1'b1;
    link_tx_reset = 1'b0;
    link_rx_reset = 1'b1;  // Held past rst to stretch the link reset.
    {rx_mac_valid, rx_mac_last, rx_usr_ready, tx_usr_valid, tx_usr_last, tx_mac_ready} = '0;
    {rx_mac_data, rx_mac_keep, tx_usr_data, tx_usr_keep} = '0;
    {rx_bp, tx_bp} = 2'b00;

    start_test("reset_hold");
    repeat (10) @(posedge rclk);
    rst <= 1'b0;
    repeat (20) begin
      @(negedge rclk);
      check_idle();
    end
    @(posedge rclk);
    link_rx_reset <= 1'b0;
    edges = 0;
    do begin
      @(posedge rclk);
      edges = edges + 1;
      @(negedge rclk);
      if (!net_ready) check_idle();
    end while (!net_ready && edges < TMO);
    // The first edge that samples all resets low is counted as well.
    if (edges != net_pkg::RESET_HOLD_CYCLES + 1) begin
      $display("ERR reset_hold expected %0d actual %0d", net_pkg::RESET_HOLD_CYCLES + 1, edges);
      tb_err++;
    end
    end_test();

    start_test("rx_passthrough");
    rx_bp = 1'b1;
    run_frames(1'b1, 40, 1, 24);
    wait_drain();
    end_test();

    start_test("tx_short_pad");
    tx_bp = 1'b1;
    run_frames(1'b0, 20, 1, 8);
    wait_drain();
    end_test();

    start_test("tx_long");
    run_frames(1'b0, 20, 9, 24);
    wait_drain();
    end_test();

    start_test("store_forward");
    tx_bp = 1'b0;  // Any break in tx_mac_valid is now the packet FIFO's doing.
    run_frames(1'b0, 20, 1, 24);
    wait_drain();
    end_test();

    start_test("link_recovery");
    tx_bp = 1'b1;
    fork
      run_frames(1'b1, 20, 1, 24);
      run_frames(1'b0, 20, 1, 24);
      begin
        repeat (60) @(posedge rclk);
        link_rx_reset <= 1'b1;
        @(posedge rclk);
        @(negedge rclk);
        check_idle();  // net_ready and every handshake port drop on the sampling edge.
        repeat (2) @(posedge rclk);
        link_rx_reset <= 1'b0;
      end
    join
    wait_net_ready();
    fork
      run_frames(1'b1, 10, 1, 24);
      run_frames(1'b0, 10, 1, 24);
    join
    wait_drain();
    end_test();

    $display("%0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
